// File: rtl/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Machine widths
`define DATA_WIDTH      32
`define REG_ADDR_WIDTH  5

// PC after reset
`define RESET_PC        32'h0000_0000

// All-zero word, SLL $0,$0,0
`define NOP_INSTR       32'h0000_0000

// Major opcodes, instr[31:26]
`define OP_RTYPE        6'b000000
`define OP_ADDIU        6'b001001
`define OP_ORI          6'b001101
`define OP_LUI          6'b001111
`define OP_LW           6'b100011
`define OP_SW           6'b101011

// R-type function codes, instr[5:0]
`define FN_ADDU         6'b100001
`define FN_SUBU         6'b100011
`define FN_AND          6'b100100
`define FN_OR           6'b100101
`define FN_SLT          6'b101010

`endif

// File: rtl/cpu_pkg.sv
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

    // One data or address word
    typedef logic [`DATA_WIDTH-1:0] word_t;

    // General register number
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

    // ALU operations of the integer subset
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,    // signed compare
        ALU_LUI     // immediate moved to the upper half
    } alu_op_t;

    // Source of an EX operand
    typedef enum logic [1:0] {
        FWD_IDEX,   // value read in ID
        FWD_MEM,    // EX/MEM result
        FWD_WB      // MEM/WB writeback data
    } fwd_sel_t;

endpackage

`default_nettype wire

// File: rtl/decode_stage.sv
`default_nettype none

`include "cpu_defines.svh"

module decode_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               mem_stall,
    input  logic               load_use_stall,
    input  cpu_pkg::word_t     ifid_instr,
    input  cpu_pkg::word_t     rs_data,
    input  cpu_pkg::word_t     rt_data,
    output cpu_pkg::reg_addr_t rs_addr,
    output cpu_pkg::reg_addr_t rt_addr,
    output cpu_pkg::reg_addr_t ex_rs_addr,
    output cpu_pkg::reg_addr_t ex_rt_addr,
    output cpu_pkg::reg_addr_t ex_rd_addr,
    output cpu_pkg::word_t     ex_op_a,
    output cpu_pkg::word_t     ex_op_b,
    output cpu_pkg::word_t     ex_imm,
    output cpu_pkg::alu_op_t   ex_alu_op,
    output logic               ex_b_sel,
    output logic               ex_reg_w,
    output logic               ex_mem_r,
    output logic               ex_mem_w
);

    import cpu_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [15:0] imm16;
    reg_addr_t  dst_addr;
    word_t      imm_ext;
    alu_op_t    id_alu_op;
    logic       id_b_sel;
    logic       id_reg_w;
    logic       id_mem_r;
    logic       id_mem_w;
    logic       id_zero_ext;
    logic       id_dst_rd;
    logic       id_uses_rt;

    assign opcode = ifid_instr[31:26];
    assign funct  = ifid_instr[5:0];
    assign imm16  = ifid_instr[15:0];

    ////////////////////////////////////////////////////////////
    // Instruction decoder
    ////////////////////////////////////////////////////////////

    // Unknown encodings fall through as a no-op
    always_comb begin
        id_alu_op   = ALU_ADD;
        id_b_sel    = 1'b0;
        id_reg_w    = 1'b0;
        id_mem_r    = 1'b0;
        id_mem_w    = 1'b0;
        id_zero_ext = 1'b0;
        id_dst_rd   = 1'b0;
        id_uses_rt  = 1'b0;
        case (opcode)
            `OP_RTYPE: begin
                id_dst_rd  = 1'b1;
                id_uses_rt = 1'b1;
                id_reg_w   = 1'b1;
                case (funct)
                    `FN_ADDU: id_alu_op = ALU_ADD;
                    `FN_SUBU: id_alu_op = ALU_SUB;
                    `FN_AND:  id_alu_op = ALU_AND;
                    `FN_OR:   id_alu_op = ALU_OR;
                    `FN_SLT:  id_alu_op = ALU_SLT;
                    default:  id_reg_w  = 1'b0;
                endcase
            end
            `OP_ADDIU: begin
                id_b_sel = 1'b1;
                id_reg_w = 1'b1;
            end
            `OP_ORI: begin
                id_alu_op   = ALU_OR;
                id_zero_ext = 1'b1;
                id_b_sel    = 1'b1;
                id_reg_w    = 1'b1;
            end
            `OP_LUI: begin
                id_alu_op = ALU_LUI;
                id_b_sel  = 1'b1;
                id_reg_w  = 1'b1;
            end
            `OP_LW: begin
                id_b_sel = 1'b1;
                id_reg_w = 1'b1;
                id_mem_r = 1'b1;
            end
            `OP_SW: begin
                id_b_sel   = 1'b1;
                id_mem_w   = 1'b1;
                id_uses_rt = 1'b1;
            end
            default: ;
        endcase
    end

    // rt only counts as a source when it is really read
    assign rs_addr  = ifid_instr[25:21];
    assign rt_addr  = id_uses_rt ? ifid_instr[20:16] : '0;
    assign dst_addr = !id_reg_w ? '0 : (id_dst_rd ? ifid_instr[15:11] : ifid_instr[20:16]);
    assign imm_ext  = id_zero_ext ? {{(`DATA_WIDTH-16){1'b0}}, imm16}
                                  : {{(`DATA_WIDTH-16){imm16[15]}}, imm16};

    ////////////////////////////////////////////////////////////
    // ID/EX register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || (load_use_stall && !mem_stall)) begin
            ex_rs_addr <= '0;
            ex_rt_addr <= '0;
            ex_rd_addr <= '0;
            ex_alu_op  <= ALU_ADD;
            ex_b_sel   <= 1'b0;
            ex_reg_w   <= 1'b0;
            ex_mem_r   <= 1'b0;
            ex_mem_w   <= 1'b0;
        end else if (!mem_stall) begin
            ex_rs_addr <= rs_addr;
            ex_rt_addr <= rt_addr;
            ex_rd_addr <= dst_addr;
            ex_alu_op  <= id_alu_op;
            ex_b_sel   <= id_b_sel;
            ex_reg_w   <= id_reg_w;
            ex_mem_r   <= id_mem_r;
            ex_mem_w   <= id_mem_w;
        end
    end

    // Operand payload
    always_ff @(posedge clk) begin
        if (!mem_stall) begin
            ex_op_a <= rs_data;
            ex_op_b <= rt_data;
            ex_imm  <= imm_ext;
        end
    end

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`default_nettype none

module execute_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               mem_stall,
    input  cpu_pkg::reg_addr_t ex_rd_addr,
    input  cpu_pkg::word_t     ex_op_a,
    input  cpu_pkg::word_t     ex_op_b,
    input  cpu_pkg::word_t     ex_imm,
    input  cpu_pkg::alu_op_t   ex_alu_op,
    input  logic               ex_b_sel,
    input  logic               ex_reg_w,
    input  logic               ex_mem_r,
    input  logic               ex_mem_w,
    input  cpu_pkg::fwd_sel_t  fwd_a_sel,
    input  cpu_pkg::fwd_sel_t  fwd_b_sel,
    input  cpu_pkg::word_t     wb_data,
    output cpu_pkg::word_t     dmem_addr,
    output cpu_pkg::word_t     dmem_wdata,
    output logic               dmem_read,
    output logic               dmem_write,
    output cpu_pkg::reg_addr_t mem_rd_addr,
    output logic               mem_reg_w,
    output logic               mem_mem_r
);

    import cpu_pkg::*;

    word_t fwd_a;
    word_t fwd_b;
    word_t alu_b;
    word_t alu_y;

    ////////////////////////////////////////////////////////////
    // Operand forwarding
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (fwd_a_sel)
            FWD_MEM: fwd_a = dmem_addr;
            FWD_WB:  fwd_a = wb_data;
            default: fwd_a = ex_op_a;
        endcase
        case (fwd_b_sel)
            FWD_MEM: fwd_b = dmem_addr;
            FWD_WB:  fwd_b = wb_data;
            default: fwd_b = ex_op_b;
        endcase
    end

    // Forwarded rt is still the store data for SW
    assign alu_b = ex_b_sel ? ex_imm : fwd_b;

    always_comb begin
        alu_y = '0;
        case (ex_alu_op)
            ALU_ADD: alu_y = fwd_a + alu_b;
            ALU_SUB: alu_y = fwd_a - alu_b;
            ALU_AND: alu_y = fwd_a & alu_b;
            ALU_OR:  alu_y = fwd_a | alu_b;
            ALU_SLT: alu_y[0] = $signed(fwd_a) < $signed(alu_b);
            ALU_LUI: alu_y = {alu_b[15:0], 16'h0000};
            default: alu_y = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // EX/MEM register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_rd_addr <= '0;
            mem_reg_w   <= 1'b0;
            mem_mem_r   <= 1'b0;
            dmem_write  <= 1'b0;
        end else if (!mem_stall) begin
            mem_rd_addr <= ex_rd_addr;
            mem_reg_w   <= ex_reg_w;
            mem_mem_r   <= ex_mem_r;
            dmem_write  <= ex_mem_w;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_stall) begin
            dmem_addr  <= alu_y;
            dmem_wdata <= fwd_b;
        end
    end

    assign dmem_read = mem_mem_r;

endmodule

`default_nettype wire

// File: rtl/fetch_stage.sv
`default_nettype none

`include "cpu_defines.svh"

module fetch_stage (
    input  logic           clk,
    input  logic           reset,
    input  logic           mem_stall,
    input  logic           load_use_stall,
    input  cpu_pkg::word_t instr,
    output cpu_pkg::word_t instr_addr,
    output cpu_pkg::word_t ifid_instr
);

    import cpu_pkg::*;

    word_t pc;
    word_t pc_next;
    logic  hold;

    // No branches in this core, so the next PC is always sequential
    assign pc_next    = pc + word_t'(4);
    assign hold       = mem_stall | load_use_stall;
    assign instr_addr = pc;

    // PC and IF/ID advance together
    always_ff @(posedge clk) begin
        if (reset) begin
            pc         <= `RESET_PC;
            ifid_instr <= `NOP_INSTR;
        end else if (!hold) begin
            pc         <= pc_next;
            ifid_instr <= instr;
        end
    end

endmodule

`default_nettype wire

// File: rtl/hazard_unit.sv
`default_nettype none

module hazard_unit (
    input  cpu_pkg::reg_addr_t rs_addr,
    input  cpu_pkg::reg_addr_t rt_addr,
    input  cpu_pkg::reg_addr_t ex_rs_addr,
    input  cpu_pkg::reg_addr_t ex_rt_addr,
    input  cpu_pkg::reg_addr_t ex_rd_addr,
    input  logic               ex_mem_r,
    input  cpu_pkg::reg_addr_t mem_rd_addr,
    input  logic               mem_reg_w,
    input  logic               mem_mem_r,
    input  cpu_pkg::reg_addr_t wb_rd_addr,
    input  logic               wb_reg_w,
    output cpu_pkg::fwd_sel_t  fwd_a_sel,
    output cpu_pkg::fwd_sel_t  fwd_b_sel,
    output logic               load_use_stall
);

    import cpu_pkg::*;

    // MEM is the younger producer and wins over WB
    function automatic fwd_sel_t pick_source(input reg_addr_t src);
        if (src == '0)
            return FWD_IDEX;
        if (mem_reg_w && !mem_mem_r && mem_rd_addr == src)
            return FWD_MEM;
        if (wb_reg_w && wb_rd_addr == src)
            return FWD_WB;
        return FWD_IDEX;
    endfunction

    always_comb begin
        fwd_a_sel = pick_source(ex_rs_addr);
        fwd_b_sel = pick_source(ex_rt_addr);
    end

    // Load data exists only after MEM, so a reader right behind it waits one cycle
    assign load_use_stall = ex_mem_r && ex_rd_addr != '0 &&
                            (ex_rd_addr == rs_addr || ex_rd_addr == rt_addr);

endmodule

`default_nettype wire

// File: rtl/pipeline.sv
`default_nettype none

module pipeline (
    input  logic               clk,
    input  logic               reset,
    output cpu_pkg::word_t     instr_addr,
    input  cpu_pkg::word_t     instr,
    output cpu_pkg::word_t     dmem_addr,
    output cpu_pkg::word_t     dmem_wdata,
    output logic               dmem_read,
    output logic               dmem_write,
    input  cpu_pkg::word_t     dmem_rdata,
    input  logic               mem_stall,
    input  cpu_pkg::reg_addr_t dbg_reg_addr,
    output cpu_pkg::word_t     dbg_reg
);

    import cpu_pkg::*;

    // IF/ID and register reads
    word_t     ifid_instr;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;

    // ID/EX
    reg_addr_t ex_rs_addr;
    reg_addr_t ex_rt_addr;
    reg_addr_t ex_rd_addr;
    word_t     ex_op_a;
    word_t     ex_op_b;
    word_t     ex_imm;
    alu_op_t   ex_alu_op;
    logic      ex_b_sel;
    logic      ex_reg_w;
    logic      ex_mem_r;
    logic      ex_mem_w;

    // EX/MEM, MEM/WB and hazard control
    reg_addr_t mem_rd_addr;
    logic      mem_reg_w;
    logic      mem_mem_r;
    logic      wb_reg_w;
    reg_addr_t wb_rd_addr;
    word_t     wb_data;
    fwd_sel_t  fwd_a_sel;
    fwd_sel_t  fwd_b_sel;
    logic      load_use_stall;

    ////////////////////////////////////////////////////////////
    // IF and ID
    ////////////////////////////////////////////////////////////

    fetch_stage u_fetch (
        .clk            ( clk            ),
        .reset          ( reset          ),
        .mem_stall      ( mem_stall      ),
        .load_use_stall ( load_use_stall ),
        .instr          ( instr          ),
        .instr_addr     ( instr_addr     ),
        .ifid_instr     ( ifid_instr     )
    );

    reg_file u_gpr (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .write        ( wb_reg_w     ),
        .rs_addr      ( rs_addr      ),
        .rt_addr      ( rt_addr      ),
        .rd_addr      ( wb_rd_addr   ),
        .rd_in        ( wb_data      ),
        .dbg_reg_addr ( dbg_reg_addr ),
        .rs_out       ( rs_data      ),
        .rt_out       ( rt_data      ),
        .dbg_reg      ( dbg_reg      )
    );

    decode_stage u_decode (
        .clk            ( clk            ),
        .reset          ( reset          ),
        .mem_stall      ( mem_stall      ),
        .load_use_stall ( load_use_stall ),
        .ifid_instr     ( ifid_instr     ),
        .rs_data        ( rs_data        ),
        .rt_data        ( rt_data        ),
        .rs_addr        ( rs_addr        ),
        .rt_addr        ( rt_addr        ),
        .ex_rs_addr     ( ex_rs_addr     ),
        .ex_rt_addr     ( ex_rt_addr     ),
        .ex_rd_addr     ( ex_rd_addr     ),
        .ex_op_a        ( ex_op_a        ),
        .ex_op_b        ( ex_op_b        ),
        .ex_imm         ( ex_imm         ),
        .ex_alu_op      ( ex_alu_op      ),
        .ex_b_sel       ( ex_b_sel       ),
        .ex_reg_w       ( ex_reg_w       ),
        .ex_mem_r       ( ex_mem_r       ),
        .ex_mem_w       ( ex_mem_w       )
    );

    hazard_unit u_hazard (
        .rs_addr        ( rs_addr        ),
        .rt_addr        ( rt_addr        ),
        .ex_rs_addr     ( ex_rs_addr     ),
        .ex_rt_addr     ( ex_rt_addr     ),
        .ex_rd_addr     ( ex_rd_addr     ),
        .ex_mem_r       ( ex_mem_r       ),
        .mem_rd_addr    ( mem_rd_addr    ),
        .mem_reg_w      ( mem_reg_w      ),
        .mem_mem_r      ( mem_mem_r      ),
        .wb_rd_addr     ( wb_rd_addr     ),
        .wb_reg_w       ( wb_reg_w       ),
        .fwd_a_sel      ( fwd_a_sel      ),
        .fwd_b_sel      ( fwd_b_sel      ),
        .load_use_stall ( load_use_stall )
    );

    ////////////////////////////////////////////////////////////
    // EX, MEM and WB
    ////////////////////////////////////////////////////////////

    execute_stage u_execute (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .mem_stall   ( mem_stall   ),
        .ex_rd_addr  ( ex_rd_addr  ),
        .ex_op_a     ( ex_op_a     ),
        .ex_op_b     ( ex_op_b     ),
        .ex_imm      ( ex_imm      ),
        .ex_alu_op   ( ex_alu_op   ),
        .ex_b_sel    ( ex_b_sel    ),
        .ex_reg_w    ( ex_reg_w    ),
        .ex_mem_r    ( ex_mem_r    ),
        .ex_mem_w    ( ex_mem_w    ),
        .fwd_a_sel   ( fwd_a_sel   ),
        .fwd_b_sel   ( fwd_b_sel   ),
        .wb_data     ( wb_data     ),
        .dmem_addr   ( dmem_addr   ),
        .dmem_wdata  ( dmem_wdata  ),
        .dmem_read   ( dmem_read   ),
        .dmem_write  ( dmem_write  ),
        .mem_rd_addr ( mem_rd_addr ),
        .mem_reg_w   ( mem_reg_w   ),
        .mem_mem_r   ( mem_mem_r   )
    );

    writeback_stage u_writeback (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .mem_stall   ( mem_stall   ),
        .dmem_addr   ( dmem_addr   ),
        .dmem_rdata  ( dmem_rdata  ),
        .mem_rd_addr ( mem_rd_addr ),
        .mem_reg_w   ( mem_reg_w   ),
        .mem_mem_r   ( mem_mem_r   ),
        .wb_reg_w    ( wb_reg_w    ),
        .wb_rd_addr  ( wb_rd_addr  ),
        .wb_data     ( wb_data     )
    );

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`default_nettype none

`include "cpu_defines.svh"

module reg_file (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       write,
    input  logic [`REG_ADDR_WIDTH-1:0] rs_addr,
    input  logic [`REG_ADDR_WIDTH-1:0] rt_addr,
    input  logic [`REG_ADDR_WIDTH-1:0] rd_addr,
    input  logic [`DATA_WIDTH-1:0]     rd_in,
    input  logic [`REG_ADDR_WIDTH-1:0] dbg_reg_addr,
    output logic [`DATA_WIDTH-1:0]     rs_out,
    output logic [`DATA_WIDTH-1:0]     rt_out,
    output logic [`DATA_WIDTH-1:0]     dbg_reg
);

    logic [`DATA_WIDTH-1:0] regs [0:(1<<`REG_ADDR_WIDTH)-1];

    // $0 reads zero, a register being written returns the new value
    function automatic logic [`DATA_WIDTH-1:0] read_port(
        input logic [`REG_ADDR_WIDTH-1:0] addr
    );
        if (addr == '0)
            return '0;
        if (write && addr == rd_addr)
            return rd_in;
        return regs[addr];
    endfunction

    always_comb begin
        rs_out  = read_port(rs_addr);
        rt_out  = read_port(rt_addr);
        dbg_reg = read_port(dbg_reg_addr);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < (1 << `REG_ADDR_WIDTH); i++)
                regs[i] <= '0;
        end else if (write && rd_addr != '0) begin
            regs[rd_addr] <= rd_in;
        end
    end

endmodule

`default_nettype wire

// File: rtl/writeback_stage.sv
`default_nettype none

module writeback_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               mem_stall,
    input  cpu_pkg::word_t     dmem_addr,
    input  cpu_pkg::word_t     dmem_rdata,
    input  cpu_pkg::reg_addr_t mem_rd_addr,
    input  logic               mem_reg_w,
    input  logic               mem_mem_r,
    output logic               wb_reg_w,
    output cpu_pkg::reg_addr_t wb_rd_addr,
    output cpu_pkg::word_t     wb_data
);

    import cpu_pkg::*;

    logic  wb_mem_r;
    word_t wb_alu;
    word_t wb_load;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_reg_w   <= 1'b0;
            wb_rd_addr <= '0;
            wb_mem_r   <= 1'b0;
        end else if (!mem_stall) begin
            wb_reg_w   <= mem_reg_w;
            wb_rd_addr <= mem_rd_addr;
            wb_mem_r   <= mem_mem_r;
        end
    end

    // Load data is sampled only once memory has answered
    always_ff @(posedge clk) begin
        if (!mem_stall) begin
            wb_alu  <= dmem_addr;
            wb_load <= dmem_rdata;
        end
    end

    assign wb_data = wb_mem_r ? wb_load : wb_alu;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the pipeline testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_pipeline -f tb.f -o sim_tb_pipeline &&
    ./obj_dir/sim_tb_pipeline | tee /dev/stderr | grep "Test OK" > /dev/null &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }

// File: tb.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/fetch_stage.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/pipeline.sv
testbench/pipeline_properties.sv
testbench/tb_pipeline.sv

// File: testbench/pipeline_properties.sv
`default_nettype none

module pipeline_properties (
    input logic           clk,
    input logic           reset,
    input logic           mem_stall,
    input cpu_pkg::word_t instr_addr,
    input cpu_pkg::word_t dmem_addr,
    input logic           dmem_read,
    input logic           dmem_write
);

    // Memory strobes come out of reset low
    strobes_idle_after_reset: assert property (
        @(posedge clk) reset |=> !dmem_read && !dmem_write
    ) else $error("memory strobe active in the cycle after reset");

    one_access_at_a_time: assert property (
        @(posedge clk) disable iff (reset) !(dmem_read && dmem_write)
    ) else $error("dmem_read and dmem_write high together");

    // A frozen cycle must not move the PC
    pc_holds_on_stall: assert property (
        @(posedge clk) disable iff (reset) mem_stall |=> $stable(instr_addr)
    ) else $error("instr_addr changed across a stalled cycle");

    word_aligned_access: assert property (
        @(posedge clk) disable iff (reset) (dmem_read || dmem_write) |-> dmem_addr[1:0] == 2'b00
    ) else $error("data memory access to an unaligned address");

endmodule

bind pipeline pipeline_properties u_props (
    .clk        ( clk        ),
    .reset      ( reset      ),
    .mem_stall  ( mem_stall  ),
    .instr_addr ( instr_addr ),
    .dmem_addr  ( dmem_addr  ),
    .dmem_read  ( dmem_read  ),
    .dmem_write ( dmem_write )
);

`default_nettype wire

// File: testbench/tb_pipeline.sv
`default_nettype none

`include "cpu_defines.svh"

module tb_pipeline;

    import cpu_pkg::*;

    localparam int PROG_LEN      = 200;
    localparam int IMEM_WORDS    = 256;
    localparam int DMEM_WORDS    = 64;
    localparam int END_PC        = (PROG_LEN + 8) * 4;
    localparam int RUN_TIMEOUT   = 2000;
    localparam int DRAIN_TIMEOUT = 100;

    logic      clk = 1'b0;
    logic      reset;
    logic      mem_stall = 1'b1;
    reg_addr_t dbg_reg_addr;
    word_t     instr_addr;
    word_t     instr;
    word_t     dmem_addr;
    word_t     dmem_wdata;
    logic      dmem_read;
    logic      dmem_write;
    word_t     dmem_rdata;
    word_t     dbg_reg;

    integer seed = 47;
    logic   scan_hold = 1'b1;
    int     commits = 0;
    int     exp_total = 0;
    int     cycles;

    word_t imem [0:IMEM_WORDS-1];
    word_t data_mem [0:DMEM_WORDS-1];
    word_t model_mem [0:DMEM_WORDS-1];
    word_t model_reg [0:31];
    word_t exp_addr [0:PROG_LEN-1];
    word_t exp_data [0:PROG_LEN-1];

    pipeline uut (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .instr_addr   ( instr_addr   ),
        .instr        ( instr        ),
        .dmem_addr    ( dmem_addr    ),
        .dmem_wdata   ( dmem_wdata   ),
        .dmem_read    ( dmem_read    ),
        .dmem_write   ( dmem_write   ),
        .dmem_rdata   ( dmem_rdata   ),
        .mem_stall    ( mem_stall    ),
        .dbg_reg_addr ( dbg_reg_addr ),
        .dbg_reg      ( dbg_reg      )
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Memory models
    ////////////////////////////////////////////////////////////

    // Past the program image the core only sees no-ops
    assign instr      = (instr_addr[31:10] == '0) ? imem[instr_addr[9:2]] : `NOP_INSTR;

    // Read data is only valid while the core asks for it
    assign dmem_rdata = dmem_read ? data_mem[dmem_addr[7:2]] : 'x;

    function automatic word_t fill_word(input int idx);
        return word_t'(32'h3c6e_f372 ^ (idx * 32'h0019_660d));
    endfunction

    // Held high until the first register scan ends, then random about one cycle in four
    always @(posedge clk) begin
        if (scan_hold)
            mem_stall <= 1'b1;
        else
            mem_stall <= (($random(seed) & 3) == 0);
    end

    // Store commit on the same edge rule as the core's memory
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DMEM_WORDS; i++)
                data_mem[i] <= fill_word(i);
        end else if (dmem_write && !mem_stall) begin
            check_store(dmem_addr, dmem_wdata);
            data_mem[dmem_addr[7:2]] <= dmem_wdata;
            commits <= commits + 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_signal(input string what, input word_t got, input word_t exp);
        if (got !== exp)
            report_failure($sformatf("mismatch at time %0t: %s is %h, expected %h",
                                     $time, what, got, exp));
    endtask

    task automatic check_reg(input reg_addr_t num, input word_t value);
        if (value !== model_reg[num])
            report_failure($sformatf("mismatch at time %0t: register %0d is %h, expected %h",
                                     $time, num, value, model_reg[num]));
    endtask

    task automatic check_store(input word_t addr, input word_t data);
        if (commits >= exp_total)
            report_failure($sformatf("store to %h at time %0t has no matching store in the model",
                                     addr, $time));
        else if (addr !== exp_addr[commits] || data !== exp_data[commits])
            report_failure($sformatf(
                "mismatch at time %0t: store %0d wrote %h to %h, expected %h to %h",
                $time, commits, data, addr, exp_data[commits], exp_addr[commits]));
    endtask

    ////////////////////////////////////////////////////////////
    // Program and ISA model
    ////////////////////////////////////////////////////////////

    // Registers 0 to 7 only so that most instructions depend on a recent one
    task automatic build_program();
        int          kind;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [15:0] imm;
        logic [15:0] offset;
        for (int i = 0; i < PROG_LEN; i++) begin
            kind   = int'({$random(seed)} % 10);
            rs     = reg_addr_t'({$random(seed)} % 8);
            rt     = reg_addr_t'({$random(seed)} % 8);
            rd     = reg_addr_t'({$random(seed)} % 8);
            imm    = 16'($random(seed));
            offset = {8'h00, 6'($random(seed)), 2'b00};
            case (kind)
                0: imem[i] = {`OP_RTYPE, rs, rt, rd, 5'd0, `FN_ADDU};
                1: imem[i] = {`OP_RTYPE, rs, rt, rd, 5'd0, `FN_SUBU};
                2: imem[i] = {`OP_RTYPE, rs, rt, rd, 5'd0, `FN_AND};
                3: imem[i] = {`OP_RTYPE, rs, rt, rd, 5'd0, `FN_OR};
                4: imem[i] = {`OP_RTYPE, rs, rt, rd, 5'd0, `FN_SLT};
                5: imem[i] = {`OP_ADDIU, rs, rt, imm};
                6: imem[i] = {`OP_ORI, rs, rt, imm};
                7: imem[i] = {`OP_LUI, 5'd0, rt, imm};
                8: imem[i] = {`OP_LW, 5'd0, rt, offset};
                default: imem[i] = {`OP_SW, 5'd0, rt, offset};
            endcase
        end
        for (int i = PROG_LEN; i < IMEM_WORDS; i++)
            imem[i] = `NOP_INSTR;
    endtask

    task automatic model_write(input reg_addr_t num, input word_t value);
        if (num != '0)
            model_reg[num] = value;
    endtask

    // One instruction at a time in program order
    task automatic run_model();
        word_t     w;
        word_t     a;
        word_t     b;
        word_t     ea;
        word_t     sext;
        word_t     zext;
        for (int i = 0; i < DMEM_WORDS; i++)
            model_mem[i] = fill_word(i);
        for (int pc = 0; pc < PROG_LEN; pc++) begin
            w    = imem[pc];
            a    = model_reg[w[25:21]];
            b    = model_reg[w[20:16]];
            sext = {{16{w[15]}}, w[15:0]};
            zext = {16'h0000, w[15:0]};
            ea   = a + sext;
            case (w[31:26])
                `OP_RTYPE: begin
                    case (w[5:0])
                        `FN_ADDU: model_write(w[15:11], a + b);
                        `FN_SUBU: model_write(w[15:11], a - b);
                        `FN_AND:  model_write(w[15:11], a & b);
                        `FN_OR:   model_write(w[15:11], a | b);
                        `FN_SLT:  model_write(w[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                        default: ;
                    endcase
                end
                `OP_ADDIU: model_write(w[20:16], a + sext);
                `OP_ORI:   model_write(w[20:16], a | zext);
                `OP_LUI:   model_write(w[20:16], {w[15:0], 16'h0000});
                `OP_LW:    model_write(w[20:16], model_mem[ea[7:2]]);
                `OP_SW: begin
                    model_mem[ea[7:2]]  = b;
                    exp_addr[exp_total] = ea;
                    exp_data[exp_total] = b;
                    exp_total++;
                end
                default: ;
            endcase
        end
    endtask

    task automatic scan_registers();
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            dbg_reg_addr <= reg_addr_t'(i);
            @(negedge clk);
            check_reg(reg_addr_t'(i), dbg_reg);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        reset        = 1'b1;
        dbg_reg_addr = '0;
        for (int i = 0; i < 32; i++)
            model_reg[i] = '0;
        build_program();
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // Reset state read while the pipeline is frozen
        @(negedge clk);
        check_signal("instr_addr", instr_addr, `RESET_PC);
        check_signal("dmem_read", word_t'(dmem_read), '0);
        check_signal("dmem_write", word_t'(dmem_write), '0);
        scan_registers();
        run_model();
        @(posedge clk);
        scan_hold <= 1'b0;

        cycles = 0;
        while (instr_addr < word_t'(END_PC)) begin
            @(negedge clk);
            cycles++;
            if (cycles > RUN_TIMEOUT)
                report_failure($sformatf("timeout: PC only reached %h after %0d cycles",
                                         instr_addr, RUN_TIMEOUT));
        end

        cycles = 0;
        while (commits != exp_total) begin
            @(negedge clk);
            cycles++;
            if (cycles > DRAIN_TIMEOUT)
                report_failure($sformatf("timeout: only %0d of %0d stores committed",
                                         commits, exp_total));
        end

        scan_registers();
        if (commits == exp_total) begin
            $display("Test OK");
            $finish;
        end else begin
            report_failure($sformatf("mismatch at time %0t: %0d stores committed, %0d expected",
                                     $time, commits, exp_total));
        end
    end

endmodule

`default_nettype wire
